/* tb.f */
hdl/mic_pkg.sv
hdl/i2s_mic_rx.sv
hdl/sample_fifo.sv
hdl/mic_capture_top.sv
dv/mic_model.sv
dv/tb_mic_capture.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the mic capture testbench with Verilator and runs it
# exit status is nonzero when the build or the simulation fails

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_exe=sim_tb_mic_capture

if ! command -v verilator > /dev/null 2>&1; then
   echo "verilator not found on PATH"
   exit 1
fi

rm -rf "$build_dir"
status=$?
if [ $status -ne 0 ]; then
   echo "could not clean $build_dir, status $status"
   exit $status
fi

verilator --binary --timing --assert -j 0 \
   -f tb.f \
   --top-module tb_mic_capture \
   -Mdir "$build_dir" \
   -o "$sim_exe"
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed, status $status"
   exit $status
fi

"./$build_dir/$sim_exe"
status=$?
if [ $status -ne 0 ]; then
   echo "simulation ended with status $status"
   exit $status
fi

echo "simulation finished with status 0"
exit 0

/* dv/tb_mic_capture.sv */
// ----------------------------------------------------------------------
// mic capture testbench with table driven frames and a FIFO reader
// ----------------------------------------------------------------------
module tb_mic_capture import mic_pkg::*;
();

   localparam int clk_div      = 4;
   localparam int adr_w        = 4;
   localparam int depth        = 1 << adr_w;
   localparam int n_rows       = 24;
   localparam int frame_cycles = 2 * slot_bits * 2 * clk_div;
   localparam int max_cycles   = (n_rows + 4) * frame_cycles;
   localparam int drive_dly    = 5;

   typedef struct packed
   {
      logic [sample_w-1:0] left;
      logic [sample_w-1:0] right;
      logic                lr;
      logic                stereo;
      logic                hold;   // reader stalled during this row
   } row_t;

   logic                mclk;
   logic                reset;
   logic                mic_sd;
   logic                lr;
   logic                stereo;
   logic                rd;
   logic                mic_sck;
   logic                mic_ws;
   mic_sample_t         rd_data;
   logic                empty;
   logic                full;
   logic                overrun;
   logic [sample_w-1:0] left_pcm;
   logic [sample_w-1:0] right_pcm;

   row_t                tbl [n_rows];
   mic_sample_t         exp_q [$];   // what the FIFO should hold
   logic                hold;
   logic                hold_req;
   logic                exp_overrun;
   int                  seed;
   int                  cycles;

   mic_capture_top
   #(
      .clk_div (clk_div),
      .adr_w   (adr_w)
   )
   u_mic_capture_top
   (
      .mclk    (mclk),
      .reset   (reset),
      .mic_sd  (mic_sd),
      .lr      (lr),
      .stereo  (stereo),
      .rd      (rd),
      .mic_sck (mic_sck),
      .mic_ws  (mic_ws),
      .rd_data (rd_data),
      .empty   (empty),
      .full    (full),
      .overrun (overrun)
   );

   mic_model u_mic
   (
      .mic_sck   (mic_sck),
      .mic_ws    (mic_ws),
      .left_pcm  (left_pcm),
      .right_pcm (right_pcm),
      .mic_sd    (mic_sd)
   );

   initial
   begin
      mclk = 1'b0;
      forever #20 mclk = ~mclk;
   end

   initial
   begin
      cycles = 0;
      forever
      begin
         @(posedge mclk);
         cycles++;
         if (cycles >= max_cycles)
            stop_run("timeout, samples stopped arriving or the FIFO never drained");
      end
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("test failed");
      $fatal(1, "simulation stopped");
   endtask

   task automatic check_val(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
      if (got !== exp)
         stop_run($sformatf("ERR %s got %h expected %h", name, got, exp));
   endtask

   // 0-2 mono left, 3-5 mono right, 6-8 stereo, 9 mono left,
   // 10-19 stereo with reader held, 20-21 stereo, 22-23 mono right
   task automatic fill_table();
      int i;
      for (i = 0; i < n_rows; i++)
      begin
         tbl[i].left   = sample_w'($random(seed));
         tbl[i].right  = sample_w'($random(seed));
         tbl[i].lr     = (i >= 3 && i < 6) || (i >= 22);
         tbl[i].stereo = (i >= 6 && i < 9) || (i >= 10 && i < 22);
         tbl[i].hold   = (i >= 10 && i < 20);
      end
   endtask

   // follows each slot on the I2S bus and queues what the FIFO must take
   task automatic track_writes();
      mic_chan_e           ch;
      logic                f_lr;
      logic                f_stereo;
      logic [sample_w-1:0] f_left;
      logic [sample_w-1:0] f_right;
      logic                wanted;
      mic_sample_t         s;
      forever
      begin
         if (!mic_ws)
         begin
            f_lr     = lr;   // mode held for the whole frame
            f_stereo = stereo;
            f_left   = left_pcm;
            f_right  = right_pcm;
         end
         ch = mic_chan_e'(mic_ws);
         repeat (pcm_last_bit + 1) @(posedge mic_sck);   // delay bit plus pcm
         @(posedge mclk);   // sample_valid is high in this cycle
         #1;
         wanted = f_stereo || (logic'(ch) == f_lr);
         if (wanted && hold && !hold_req)
         begin
            // release so the pop lands on the same edge as this write
            check_val("full", 32'(full), 32'd1);
            check_val("overrun", 32'(overrun), 32'd1);
            hold = 1'b0;
         end
         #9;
         if (wanted)
         begin
            s.chan = ch;
            s.pcm  = (ch == chan_right) ? f_right : f_left;
            if (exp_q.size() < depth)
               exp_q.push_back(s);
            else
               exp_overrun = 1'b1;   // full without a pop drops the write
         end
         @(mic_ws);
      end
   endtask

   task automatic read_samples();
      mic_sample_t head;
      forever
      begin
         @(posedge mclk);
         #drive_dly;
         check_val("empty", 32'(empty), 32'(exp_q.size() == 0));
         check_val("full", 32'(full), 32'(exp_q.size() == depth));
         check_val("overrun", 32'(overrun), 32'(exp_overrun));
         if (!empty && !hold)
         begin
            head = exp_q.pop_front();
            check_val("rd_data", {15'd0, rd_data}, {15'd0, head});
            rd = 1'b1;   // pops the head at the next edge
         end
         else
         begin
            rd = 1'b0;
         end
      end
   endtask

   initial
   begin
      int i;
      seed        = 7;
      reset       = 1'b1;
      lr          = 1'b0;
      stereo      = 1'b0;
      rd          = 1'b0;
      left_pcm    = '0;
      right_pcm   = '0;
      hold        = 1'b0;
      hold_req    = 1'b0;
      exp_overrun = 1'b0;
      fill_table();

      repeat (4) @(posedge mclk);
      #drive_dly;
      reset = 1'b0;
      check_val("mic_sck", 32'(mic_sck), 32'd0);
      check_val("mic_ws", 32'(mic_ws), 32'd0);
      check_val("empty", 32'(empty), 32'd1);
      check_val("full", 32'(full), 32'd0);
      check_val("overrun", 32'(overrun), 32'd0);

      fork
         track_writes();
         read_samples();
      join_none

      // row i is set up during the right slot of the frame before it
      for (i = 0; i < n_rows; i++)
      begin
         @(posedge mic_ws);
         @(posedge mclk);
         #drive_dly;
         lr        = tbl[i].lr;
         stereo    = tbl[i].stereo;
         left_pcm  = tbl[i].left;
         right_pcm = tbl[i].right;
         hold_req  = tbl[i].hold;
         if (tbl[i].hold)
            hold = 1'b1;
      end

      @(negedge mic_ws);   // frame of the last row starts
      @(negedge mic_ws);   // and ends
      while (exp_q.size() != 0)
         @(posedge mclk);
      @(posedge mclk);
      #drive_dly;
      check_val("empty", 32'(empty), 32'd1);
      check_val("overrun", 32'(overrun), 32'd1);
      $display("test passed");
      $finish;
   end

endmodule

/* dv/mic_model.sv */
// ----------------------------------------------------------------------
// behavioral I2S MEMS microphone, shifts given PCM words onto mic_sd
// ----------------------------------------------------------------------
module mic_model import mic_pkg::*;
(
   input  logic                mic_sck,
   input  logic                mic_ws,
   input  logic [sample_w-1:0] left_pcm,    // word for the ws low slot
   input  logic [sample_w-1:0] right_pcm,   // word for the ws high slot
   output logic                mic_sd
);

   logic                sck_last;
   logic                fell;
   logic                ws_seen;
   logic [sample_w-1:0] word;
   int                  pos;   // slot bit being driven

   initial
   begin
      sck_last = 1'b0;
      fell     = 1'b0;
      ws_seen  = 1'b0;
      word     = '0;   // line is quiet in the first slot after reset
      pos      = 0;
      mic_sd   = 1'b0;
   end

   // only a real 1 to 0 transition counts as a falling sck
   always @(mic_sck)
   begin
      fell     = (sck_last === 1'b1) && (mic_sck === 1'b0);
      sck_last = mic_sck;
      if (fell)
      begin
         #2;   // data changes shortly after the falling edge
         if (mic_ws !== ws_seen)
         begin
            // new slot, grab the word for this channel
            ws_seen = mic_ws;
            pos     = 0;
            word    = mic_ws ? right_pcm : left_pcm;
         end
         else
         begin
            pos = pos + 1;
         end

         if (pos >= pcm_first_bit && pos <= pcm_last_bit)
         begin
            mic_sd = word[sample_w-1];   // MSB first
            word   = word << 1;
         end
         else
         begin
            mic_sd = 1'b0;   // delay bit and padding
         end
      end
   end

endmodule

/* hdl/mic_capture_top.sv */
// ----------------------------------------------------------------------
// microphone capture top: I2S receiver feeding the sample FIFO
// ----------------------------------------------------------------------
module mic_capture_top import mic_pkg::*;
#(
   parameter int clk_div = 4,   // half sck period in mclk cycles
   parameter int adr_w   = 4    // 16 entry FIFO
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        mic_sd,
   input  logic        lr,
   input  logic        stereo,
   input  logic        rd,
   output logic        mic_sck,
   output logic        mic_ws,
   output mic_sample_t rd_data,
   output logic        empty,
   output logic        full,
   output logic        overrun
);

   mic_sample_t sample;
   logic        sample_valid;   // no back-pressure toward the receiver

   i2s_mic_rx
   #(
      .clk_div (clk_div)
   )
   u_rx
   (
      .mclk         (mclk),
      .reset        (reset),
      .mic_sd       (mic_sd),
      .lr           (lr),
      .stereo       (stereo),
      .mic_sck      (mic_sck),
      .mic_ws       (mic_ws),
      .sample       (sample),
      .sample_valid (sample_valid)
   );

   sample_fifo
   #(
      .adr_w     (adr_w),
      .payload_t (mic_sample_t)
   )
   u_fifo
   (
      .mclk    (mclk),
      .reset   (reset),
      .wr      (sample_valid),
      .wr_data (sample),
      .rd      (rd),
      .rd_data (rd_data),
      .empty   (empty),
      .full    (full),
      .overrun (overrun)
   );

endmodule

/* hdl/sample_fifo.sv */
// ----------------------------------------------------------------------
// circular sample FIFO with show-ahead read and sticky overrun flag
// ----------------------------------------------------------------------
module sample_fifo
#(
   parameter int  adr_w     = 4,
   parameter type payload_t = logic [15:0]
)
(
   input  logic     mclk,
   input  logic     reset,
   input  logic     wr,
   input  payload_t wr_data,
   input  logic     rd,
   output payload_t rd_data,
   output logic     empty,
   output logic     full,
   output logic     overrun
);

   localparam int depth = 1 << adr_w;

   payload_t         mem [0:depth-1];
   logic [adr_w-1:0] wr_ptr;
   logic [adr_w-1:0] rd_ptr;
   logic [adr_w:0]   count;   // top bit set only when full
   logic             do_wr;
   logic             do_rd;

   assign empty = (count == '0);
   assign full  = count[adr_w];

   // a pop frees a slot in the same cycle
   assign do_rd = rd && !empty;
   assign do_wr = wr && (!full || do_rd);

   // head of queue always visible
   assign rd_data = mem[rd_ptr];

   always_ff @(posedge mclk)
   begin
      if (do_wr)
         mem[wr_ptr] <= wr_data;
   end

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;   // wraps around the array
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_wr, do_rd})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;   // idle or push with pop
         endcase
      end
   end

   // a dropped write sets it until reset
   always_ff @(posedge mclk)
   begin
      if (reset)
         overrun <= 1'b0;
      else if (wr && !do_wr)
         overrun <= 1'b1;
   end

   // no slot is overwritten while full without a pop
   a_no_wr_full : assert property (@(posedge mclk) disable iff (reset)
      (full && !rd) |=> $stable(wr_ptr));

   // count never passes depth so full and empty stay apart
   a_count_range : assert property (@(posedge mclk) disable iff (reset)
      count <= (adr_w+1)'(depth));

endmodule

/* hdl/i2s_mic_rx.sv */
// ----------------------------------------------------------------------
// I2S microphone receiver: sck and ws generation, serial to parallel
// ----------------------------------------------------------------------
module i2s_mic_rx import mic_pkg::*;
#(
   parameter int clk_div = 4   // mclk cycles per half sck period
)
(
   input  logic        mclk,
   input  logic        reset,
   input  logic        mic_sd,
   input  logic        lr,
   input  logic        stereo,
   output logic        mic_sck,
   output logic        mic_ws,
   output mic_sample_t sample,
   output logic        sample_valid
);

   localparam int div_w  = $clog2(clk_div);
   localparam int slot_w = $clog2(slot_bits);

   logic [div_w-1:0]     div_cnt;
   logic                 sck_q;
   logic                 tick;
   logic                 rise_tick;
   logic                 fall_tick;
   logic [bit_cnt_w-1:0] bit_cnt;
   logic [slot_w-1:0]    slot_pos;
   logic                 slot_right;
   logic                 frame_start;
   logic                 lr_q;
   logic                 stereo_q;
   logic                 pcm_bit;
   logic                 last_bit;
   logic                 wanted;
   logic [sample_w-1:0]  shreg;
   logic                 take;

   // sck divider
   assign tick      = (div_cnt == div_w'(clk_div - 1));
   assign rise_tick = tick && !sck_q;   // sck goes high at this edge
   assign fall_tick = tick && sck_q;

   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         div_cnt <= '0;
         sck_q   <= 1'b0;
      end
      else if (tick)
      begin
         div_cnt <= '0;
         sck_q   <= ~sck_q;
      end
      else
      begin
         div_cnt <= div_cnt + 1'b1;
      end
   end

   // frame position, advances on falling sck only
   always_ff @(posedge mclk)
   begin
      if (reset)
         bit_cnt <= '0;                  // new left slot
      else if (fall_tick)
         bit_cnt <= bit_cnt + 1'b1;      // wraps into next frame
   end

   assign slot_right  = bit_cnt[bit_cnt_w-1];
   assign slot_pos    = bit_cnt[slot_w-1:0];
   assign frame_start = fall_tick && (bit_cnt == '1);   // ws falls into left

   // mode pins are held for a whole frame
   always_ff @(posedge mclk)
   begin
      if (reset || frame_start)
      begin
         lr_q     <= lr;
         stereo_q <= stereo;
      end
   end

   assign pcm_bit  = (slot_pos >= slot_w'(pcm_first_bit)) &&
                     (slot_pos <= slot_w'(pcm_last_bit));
   assign last_bit = (slot_pos == slot_w'(pcm_last_bit));
   assign wanted   = stereo_q || (slot_right == lr_q);

   // sample mic_sd as sck rises
   always_ff @(posedge mclk)
   begin
      if (rise_tick && pcm_bit)
         shreg <= {shreg[sample_w-2:0], mic_sd};
   end

   // take marks the cycle after the LSB was shifted in
   always_ff @(posedge mclk)
   begin
      if (reset)
      begin
         take         <= 1'b0;
         sample_valid <= 1'b0;
      end
      else
      begin
         take         <= rise_tick && last_bit && wanted;
         sample_valid <= take;
      end
   end

   // slot cannot have moved yet since clk_div >= 2
   always_ff @(posedge mclk)
   begin
      if (take)
      begin
         sample.chan <= mic_chan_e'(slot_right);
         sample.pcm  <= shreg;
      end
   end

   assign mic_sck = sck_q;
   assign mic_ws  = slot_right;

   // one write strobe per wanted slot
   a_valid_pulse : assert property (@(posedge mclk) disable iff (reset)
      sample_valid |=> !sample_valid);

   // I2S framing rule seen by the microphone
   a_ws_on_low_sck : assert property (@(posedge mclk) disable iff (reset)
      $changed(mic_ws) |-> !mic_sck);

endmodule

/* hdl/mic_pkg.sv */
// ----------------------------------------------------------------------
// mic capture package: sample type, channel tag and I2S frame constants
// ----------------------------------------------------------------------
package mic_pkg;

   // PCM width of the MEMS microphone
   localparam int sample_w = 16;

   // sck periods per channel slot
   localparam int slot_bits = 32;

   // one frame is a left slot followed by a right slot
   localparam int frame_bits = 2 * slot_bits;
   localparam int bit_cnt_w  = $clog2(frame_bits);

   // slot bit 0 is the one-bit I2S delay
   localparam int pcm_first_bit = 1;
   localparam int pcm_last_bit  = sample_w;   // MSB first, LSB lands here

   // ws low selects left, ws high selects right
   typedef enum logic
   {
      chan_left  = 1'b0,
      chan_right = 1'b1
   } mic_chan_e;

   // one captured PCM word with the slot it came from
   typedef struct packed
   {
      mic_chan_e           chan;
      logic [sample_w-1:0] pcm;
   } mic_sample_t;

endpackage
